/* tb.f */
+incdir+logic
logic/snd_pkg.sv
logic/snd_ctrl_if.sv
logic/snd_voice_if.sv
logic/snd_cmd_decode.sv
logic/snd_voice_gen.sv
logic/snd_mixer.sv
logic/snd_top.sv
verif/snd_checker.sv
verif/snd_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module snd_tb -o snd_sim
out=$(./obj_dir/snd_sim)
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1

/* verif/snd_tb.sv */
`include "snd_macros.svh"

module snd_tb import snd_pkg::*; ();

localparam int N_CMDS     = 200;
localparam int CMD_BUDGET = 80;      // cycles allowed per command
localparam int PERIOD     = 100;
localparam int TAIL       = 2 * `SND_PCM_LEN * `SND_SAMPLE_DIV + 200;  // last block with stalls
localparam int WATCHDOG   = (N_CMDS * CMD_BUDGET + TAIL + 1000) * PERIOD;
localparam int LAST_BLK   = 517;
localparam logic [16:0] LAST_ADDR = 17'((LAST_BLK + 1) * `SND_PCM_LEN - 1);  // final byte

logic        clk;
logic        rst;
logic        cmd_req;
logic [15:0] cmd_data;
logic        cmd_ack;
logic [16:0] pcm_addr;
logic        pcm_cs;
logic [7:0]  pcm_data = 8'h00;
logic        pcm_ok = 1'b0;
snd_sample_t snd;
logic        sample;
logic        peak;
int          mismatches;
int          proto_errs;
integer      seed;
int          rom_wait;             // cycles left before pcm_ok or -1 when idle

snd_top uut (.*);

snd_checker chk (.*);

initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
end

// 0 to n-1
function automatic int pick(input int n);
    return int'({$random(seed)} % n);
endfunction

function automatic logic [15:0] random_cmd();
    int         kind;
    logic [3:0] op;
    logic [1:0] ch;
    logic [9:0] arg;
    kind = pick(16);
    if (kind < 4)       op = OP_TONE_PERIOD;
    else if (kind < 7)  op = OP_TONE_VOL;
    else if (kind < 9)  op = OP_PCM_START;
    else if (kind < 10) op = OP_PCM_STOP;
    else if (kind < 13) op = OP_GAIN;
    else if (kind < 14) op = OP_NOP;
    else                op = 4'(pick(16));  // unused codes too
    ch = (pick(8) == 0) ? 2'd3 : 2'(pick(3));
    case (op)
        OP_TONE_PERIOD: arg = 10'(1 + pick(12));
        OP_TONE_VOL:    arg = 10'(pick(256));
        OP_GAIN:        arg = 10'(pick(65));   // up to 4.0 so the mix saturates
        default:        arg = 10'(pick(1024));
    endcase
    return {op, ch, arg};
endfunction

// four-phase write that returns with req and ack both low
task automatic send_cmd(input logic [15:0] data);
    @(posedge clk);
    cmd_data <= data;
    cmd_req  <= 1'b1;
    @(posedge clk);
    while (!cmd_ack) @(posedge clk);
    cmd_req <= 1'b0;
    @(posedge clk);
    while (cmd_ack) @(posedge clk);
endtask

// sample ROM with 1 to 24 cycles of latency
always @(posedge clk) begin
    if (rst) begin
        pcm_ok <= 1'b0;
        rom_wait = -1;
    end else if (pcm_ok) begin
        pcm_ok <= 1'b0;                // byte taken on this edge
    end else if (pcm_cs) begin
        if (rom_wait < 0) rom_wait = 1 + pick(24);
        rom_wait = rom_wait - 1;
        if (rom_wait == 0) begin
            pcm_ok   <= 1'b1;
            pcm_data <= pcm_addr[7:0] ^ 8'h5a;
            rom_wait = -1;
        end
    end
end

initial begin
    seed     = 32'h018df582;
    rst      = 1'b1;
    cmd_req  = 1'b0;
    cmd_data = 16'h0000;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    for (int n = 0; n < N_CMDS; n++) begin
        send_cmd(random_cmd());
        repeat (pick(40)) @(posedge clk);  // idle gap
    end
    send_cmd({OP_PCM_START, 2'd2, 10'(LAST_BLK)});  // one block left to play out
    while (!(pcm_cs && pcm_ok && pcm_addr == LAST_ADDR)) @(posedge clk);
    repeat (2 * `SND_SAMPLE_DIV) @(posedge clk);  // silence reaches snd
    @(negedge clk);
    $display("mismatches %0d, handshake errors %0d", mismatches, proto_errs);
    if (mismatches + proto_errs == 0) begin
        $display("NO ERRORS");
    end else begin
        $display("ERRORS FOUND");
    end
    $finish;
end

initial begin
    #(WATCHDOG);
    $display("Timeout: run still going after %0d time units", WATCHDOG);
    $display("mismatches %0d, handshake errors %0d", mismatches, proto_errs);
    $display("ERRORS FOUND");
    $finish;
end

endmodule

/* verif/snd_checker.sv */
`include "snd_macros.svh"

module snd_checker import snd_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_req,
    input  logic [15:0] cmd_data,
    input  logic        cmd_ack,
    input  logic [16:0] pcm_addr,
    input  logic        pcm_cs,
    input  logic [7:0]  pcm_data,
    input  logic        pcm_ok,
    input  snd_sample_t snd,
    input  logic        sample,
    input  logic        peak,
    output int          mismatches,
    output int          proto_errs
);

localparam int DIV = `SND_SAMPLE_DIV;
localparam int LEN = `SND_PCM_LEN;

// model state, each value as it stands after the last edge
int div;
bit tick;                                 // tick register toward mixer
bit m_sample;
bit m_peak;
int m_snd;
int period [2];
int vol [2];
int gain [3];
int last_per [2];
int cnt [2];
bit ph [2];                               // 1 is the negative half
int tone [2];
bit start_p;
bit stop_p;
int block;
bit playing;
bit cur;                                  // pending fetch is for this block
bit pend;                                 // fetch out at the ROM
bit fresh;
int ptr;
int addr;
int bytes;
int held;
int ch_pcm;
bit ack_q;
bit req_q;
bit first;
int rel_wait;                             // cycles of ack high with req low

// channel times 4.4 gain, floor of the divide by 16
function automatic int weigh(input int ch, input int g);
    return (ch * g) >>> 4;
endfunction

task automatic check_val(input string name, input logic signed [31:0] got, input int exp);
    if (got !== exp) begin
        $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        mismatches++;
    end
endtask

task automatic proto_fail(input string what);
    $display("Handshake error at %0t: %s", $time, what);
    proto_errs++;
endtask

task automatic reset_model();
    div = 0;
    tick = 0;
    m_sample = 0;
    m_peak = 0;
    m_snd = 0;
    for (int i = 0; i < 2; i++) begin
        period[i] = 0;
        vol[i] = 0;
        last_per[i] = 0;
        cnt[i] = 0;
        ph[i] = 0;
        tone[i] = 0;
    end
    for (int i = 0; i < 3; i++) gain[i] = int'(`SND_GAIN_RESET);
    {start_p, stop_p, playing, cur, pend, fresh} = '0;
    {block, ptr, addr, bytes, held, ch_pcm} = '0;
    {ack_q, req_q, rel_wait} = '0;
    first = 1;
    mismatches = 0;
    proto_errs = 0;
endtask

task automatic check_handshake();
    if (first && cmd_ack !== 1'b0) proto_fail("cmd_ack is not low after reset");
    first = 0;
    if (cmd_ack && !ack_q && !req_q) proto_fail("cmd_ack rose with no cmd_req");
    if (!cmd_ack && ack_q && req_q) proto_fail("cmd_ack fell while cmd_req was still high");
    rel_wait = (cmd_ack && !cmd_req) ? rel_wait + 1 : 0;
    if (rel_wait == 3) proto_fail("cmd_ack still high two cycles after cmd_req fell");
    ack_q = cmd_ack;
    req_q = cmd_req;
endtask

task automatic step_model();
    bit      tick_now;
    bit      accept;
    bit      issue;
    int      sum;
    int      chn;
    int      arg;
    snd_op_e op;
    tick_now = (div == DIV - 1);
    accept   = pend && pcm_ok;
    issue    = tick_now && playing && !pend && !start_p && !stop_p;
    // mixer sees channels from the tick edge and gains as of now
    m_sample = tick;
    if (tick) begin
        sum    = weigh(tone[0], gain[0]) + weigh(tone[1], gain[1]) + weigh(ch_pcm, gain[2]);
        m_peak = (sum > 32767) || (sum < -32768);
        m_snd  = (sum > 32767) ? 32767 : ((sum < -32768) ? -32768 : sum);
    end
    tick = tick_now;
    div  = tick_now ? 0 : div + 1;
    if (tick_now) begin
        for (int i = 0; i < 2; i++) begin
            if (period[i] == 0) begin
                cnt[i] = 0;
                ph[i]  = 0;
            end else if (period[i] != last_per[i]) begin
                cnt[i] = 0;                   // new period, count again
            end else if (cnt[i] + 1 >= period[i]) begin
                cnt[i] = 0;
                ph[i]  = !ph[i];
            end else begin
                cnt[i]++;
            end
            last_per[i] = period[i];
            tone[i] = (period[i] == 0) ? 0 : (ph[i] ? -64 * vol[i] : 64 * vol[i]);
        end
        if (!playing)
            ch_pcm = 0;
        else if (fresh)
            ch_pcm = ((held >= 128) ? held - 256 : held) * 256;  // signed byte
        fresh = 0;                            // stalled fetch, old sample stays
    end
    if (issue) begin
        pend = 1;
        addr = ptr;
        cur  = 1;
    end
    if (accept) begin
        pend = 0;
        if (cur) begin
            held  = int'(pcm_data);
            fresh = 1;
            ptr   = (ptr + 1) & 32'h1ffff;
            bytes++;
            if (bytes == LEN) playing = 0;   // whole block played
        end
        cur = 0;
    end
    if (stop_p) begin
        playing = 0;
        cur     = 0;
    end
    if (start_p) begin
        ptr     = block * LEN;
        bytes   = 0;
        playing = 1;
        cur     = 0;
        fresh   = 0;
    end
    // command taken on the edge where ack rises
    start_p = 0;
    stop_p  = 0;
    if (cmd_req && !cmd_ack) begin
        op  = snd_op_e'(cmd_data[15:12]);
        chn = int'(cmd_data[11:10]);
        arg = int'(cmd_data[9:0]);
        case (op)
            OP_TONE_PERIOD: if (chn < 2) period[chn] = arg;
            OP_TONE_VOL:    if (chn < 2) vol[chn] = arg & 255;
            OP_PCM_START: begin
                start_p = 1;
                block   = arg;
            end
            OP_PCM_STOP:    stop_p = 1;
            OP_GAIN:        if (chn < 3) gain[chn] = arg & 255;
            default: ;                        // nop and unused codes
        endcase
    end
endtask

always @(posedge clk) begin
    if (rst) begin
        reset_model();
    end else begin
        check_val("sample", 32'(sample), int'(m_sample));
        check_val("snd", 32'(snd), m_snd);
        check_val("peak", 32'(peak), int'(m_peak));
        check_val("pcm_cs", 32'(pcm_cs), int'(pend));
        if (pend) check_val("pcm_addr", 32'(pcm_addr), addr);  // held while waiting
        check_handshake();
        step_model();
    end
end

endmodule

/* logic/snd_top.sv */
`include "snd_macros.svh"

module snd_top import snd_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    // command latch from main CPU
    input  logic                   cmd_req,
    input  logic [15:0]            cmd_data,
    output logic                   cmd_ack,
    // sample ROM
    output logic [`SND_PCM_AW-1:0] pcm_addr,
    output logic                   pcm_cs,
    input  logic [7:0]             pcm_data,
    input  logic                   pcm_ok,
    // sound out
    output snd_sample_t            snd,
    output logic                   sample,
    output logic                   peak
);

snd_ctrl_if  ctrl ();   // decode to voices and mixer
snd_voice_if voice ();  // voices to mixer

snd_cmd_decode u_dec (
    .clk      ( clk      ),
    .rst      ( rst      ),
    .cmd_req  ( cmd_req  ),
    .cmd_data ( cmd_data ),
    .cmd_ack  ( cmd_ack  ),
    .ctrl     ( ctrl.dec )
);

snd_voice_gen u_gen (
    .clk      ( clk       ),
    .rst      ( rst       ),
    .ctrl     ( ctrl.gen  ),
    .voice    ( voice.gen ),
    .pcm_addr ( pcm_addr  ),
    .pcm_cs   ( pcm_cs    ),
    .pcm_data ( pcm_data  ),
    .pcm_ok   ( pcm_ok    )
);

snd_mixer u_mix (
    .clk    ( clk       ),
    .rst    ( rst       ),
    .voice  ( voice.mix ),
    .ctrl   ( ctrl.mix  ),  // gains only
    .snd    ( snd       ),
    .sample ( sample    ),
    .peak   ( peak      )
);

endmodule

/* logic/snd_mixer.sv */
module snd_mixer import snd_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    snd_voice_if.mix    voice,
    snd_ctrl_if.mix     ctrl,
    output snd_sample_t snd,
    output logic        sample,
    output logic        peak
);

logic signed [22:0] mix_sum;  // full width, no overflow
logic               over;
logic               under;

// channel times 4.4 gain, fraction bits dropped
function automatic logic signed [20:0] weigh(input snd_sample_t ch, input logic [7:0] g);
    logic signed [24:0] prod;
    prod = ch * $signed({1'b0, g});
    return prod[24:4];
endfunction

assign mix_sum = weigh(voice.ch_tone0, ctrl.gain[0])
               + weigh(voice.ch_tone1, ctrl.gain[1])
               + weigh(voice.ch_pcm,   ctrl.gain[2]);
assign over    = mix_sum > 23'sd32767;
assign under   = mix_sum < -23'sd32768;

always_ff @(posedge clk) begin
    if (rst) begin
        snd    <= '0;
        sample <= 1'b0;
        peak   <= 1'b0;
    end else begin
        sample <= voice.tick;  // one cycle strobe
        if (voice.tick) begin
            peak <= over || under;  // held with snd
            if (over)
                snd <= 16'sh7fff;
            else if (under)
                snd <= 16'sh8000;
            else
                snd <= mix_sum[15:0];
        end
    end
end

// tick spacing keeps the strobe isolated
a_sample_pulse: assert property (
    @(posedge clk) disable iff (rst)
    sample |=> !sample
);

endmodule

/* logic/snd_voice_gen.sv */
`include "snd_macros.svh"

module snd_voice_gen import snd_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    snd_ctrl_if.gen     ctrl,
    snd_voice_if.gen    voice,
    output logic [16:0] pcm_addr,
    output logic        pcm_cs,
    input  logic [7:0]  pcm_data,
    input  logic        pcm_ok
);

localparam int DIV   = `SND_SAMPLE_DIV;
localparam int DIV_W = $clog2(DIV);
localparam int LEN   = `SND_PCM_LEN;
localparam int CNT_W = $clog2(LEN + 1);
localparam int AW    = `SND_PCM_AW;

logic [DIV_W-1:0] div_cnt;
logic             tick_now;  // this edge is the tick edge

// tone voices
logic [9:0]  tone_cnt    [2];
logic [9:0]  last_period [2];
logic        tone_ph     [2];  // 1 means negative half
logic [9:0]  cnt_nx      [2];
logic        ph_nx       [2];
snd_sample_t tone_q      [2];

// pcm voice
logic [AW-1:0]    pcm_ptr;   // next address to fetch
logic [CNT_W-1:0] pcm_cnt;   // accepted bytes in block
logic             playing;
logic             cur;       // pending fetch belongs to this block
logic [7:0]       held;
logic             fresh;     // held byte not shown yet
logic             accept;
logic             issue;
snd_sample_t      ch_pcm_q;

assign tick_now = (div_cnt == DIV_W'(DIV - 1));
assign accept   = pcm_cs && pcm_ok;
// start or stop on the tick edge wins over a new fetch
assign issue    = tick_now && playing && !pcm_cs && !ctrl.pcm_start && !ctrl.pcm_stop;

always_ff @(posedge clk) begin
    if (rst) begin
        div_cnt    <= '0;
        voice.tick <= 1'b0;
    end else begin
        div_cnt    <= tick_now ? '0 : div_cnt + 1'b1;
        voice.tick <= tick_now;  // channels are already new
    end
end

always_comb begin
    for (int i = 0; i < 2; i++) begin
        cnt_nx[i] = tone_cnt[i] + 10'd1;
        ph_nx[i]  = tone_ph[i];
        if (ctrl.tone_period[i] == '0) begin  // muted
            cnt_nx[i] = '0;
            ph_nx[i]  = 1'b0;
        end else if (ctrl.tone_period[i] != last_period[i]) begin
            cnt_nx[i] = '0;  // new period restarts count
        end else if (cnt_nx[i] >= ctrl.tone_period[i]) begin
            cnt_nx[i] = '0;
            ph_nx[i]  = ~tone_ph[i];  // half period done
        end
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < 2; i++) begin
            tone_cnt[i]    <= '0;
            last_period[i] <= '0;
            tone_ph[i]     <= 1'b0;
            tone_q[i]      <= '0;
        end
    end else if (tick_now) begin
        for (int i = 0; i < 2; i++) begin
            tone_cnt[i]    <= cnt_nx[i];
            tone_ph[i]     <= ph_nx[i];
            last_period[i] <= ctrl.tone_period[i];
            if (ctrl.tone_period[i] == '0)
                tone_q[i] <= '0;
            else if (ph_nx[i])
                tone_q[i] <= -snd_sample_t'({2'b00, ctrl.tone_vol[i], 6'b0});  // vol*64
            else
                tone_q[i] <= snd_sample_t'({2'b00, ctrl.tone_vol[i], 6'b0});
        end
    end
end

assign voice.ch_tone0 = tone_q[0];
assign voice.ch_tone1 = tone_q[1];

always_ff @(posedge clk) begin
    if (rst) begin
        pcm_cs   <= 1'b0;
        pcm_addr <= '0;
        pcm_ptr  <= '0;
        pcm_cnt  <= '0;
        playing  <= 1'b0;
        cur      <= 1'b0;
        fresh    <= 1'b0;
        ch_pcm_q <= '0;
    end else begin
        if (tick_now) begin
            if (!playing)
                ch_pcm_q <= '0;
            else if (fresh)
                ch_pcm_q <= {held, 8'h00};  // byte*256
            fresh <= 1'b0;  // stalled fetch keeps old sample
        end
        if (issue) begin
            pcm_cs   <= 1'b1;
            pcm_addr <= pcm_ptr;  // held until pcm_ok
            cur      <= 1'b1;
        end
        if (accept) begin
            pcm_cs <= 1'b0;
            cur    <= 1'b0;
            if (cur) begin
                held    <= pcm_data;
                fresh   <= 1'b1;
                pcm_ptr <= pcm_ptr + 1'b1;
                pcm_cnt <= pcm_cnt + 1'b1;
                if (pcm_cnt == CNT_W'(LEN - 1)) playing <= 1'b0;  // block done
            end
        end
        if (ctrl.pcm_stop) begin
            playing <= 1'b0;
            cur     <= 1'b0;  // pending fetch finishes, byte dropped
        end
        if (ctrl.pcm_start) begin
            pcm_ptr <= AW'(ctrl.pcm_block) * AW'(LEN);
            pcm_cnt <= '0;
            playing <= 1'b1;
            cur     <= 1'b0;
            fresh   <= 1'b0;
        end
    end
end

assign voice.ch_pcm = ch_pcm_q;

// ROM request must hold still until answered
a_addr_stable: assert property (
    @(posedge clk) disable iff (rst)
    pcm_cs && !pcm_ok |=> pcm_cs && $stable(pcm_addr)
);

endmodule

/* logic/snd_cmd_decode.sv */
`include "snd_macros.svh"

module snd_cmd_decode import snd_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_req,
    input  logic [15:0] cmd_data,
    output logic        cmd_ack,
    snd_ctrl_if.dec     ctrl
);

snd_dec_state_e state;
snd_op_e        op;
logic [1:0]     ch;   // 0,1 tones, 2 pcm
logic [9:0]     arg;

assign op      = snd_op_e'(cmd_data[15:12]);
assign ch      = cmd_data[11:10];
assign arg     = cmd_data[9:0];
assign cmd_ack = (state == ACKED);  // ack is the state bit itself

always_ff @(posedge clk) begin
    if (rst) begin
        state          <= IDLE;
        ctrl.pcm_start <= 1'b0;
        ctrl.pcm_stop  <= 1'b0;
        for (int i = 0; i < 2; i++) begin
            ctrl.tone_period[i] <= '0;
            ctrl.tone_vol[i]    <= '0;
        end
        for (int i = 0; i < 3; i++) begin
            ctrl.gain[i] <= `SND_GAIN_RESET;
        end
    end else begin
        ctrl.pcm_start <= 1'b0;  // pulses last one cycle
        ctrl.pcm_stop  <= 1'b0;
        case (state)
            IDLE: begin
                if (cmd_req) begin  // data is stable while req is up
                    state <= ACKED;
                    case (op)
                        OP_TONE_PERIOD: begin
                            if (!ch[1]) ctrl.tone_period[ch[0]] <= arg;
                        end
                        OP_TONE_VOL: begin
                            if (!ch[1]) ctrl.tone_vol[ch[0]] <= arg[7:0];
                        end
                        OP_PCM_START: begin
                            ctrl.pcm_start <= 1'b1;
                            ctrl.pcm_block <= arg;
                        end
                        OP_PCM_STOP: ctrl.pcm_stop <= 1'b1;
                        OP_GAIN: begin
                            if (ch != 2'd3) ctrl.gain[ch] <= arg[7:0];  // ch 3 unused
                        end
                        default: ;  // NOP and unknown codes
                    endcase
                end
            end
            ACKED: begin
                if (!cmd_req) state <= IDLE;  // host released, drop ack
            end
            default: state <= IDLE;
        endcase
    end
end

// host side must see ack until it lets go of req
a_ack_holds: assert property (
    @(posedge clk) disable iff (rst)
    cmd_ack && cmd_req |=> cmd_ack
);

endmodule

/* logic/snd_voice_if.sv */
// channel samples towards the mixer
interface snd_voice_if import snd_pkg::*; ();

    snd_sample_t ch_tone0;
    snd_sample_t ch_tone1;
    snd_sample_t ch_pcm;
    logic        tick;  // high the cycle after channels update

    modport gen (
        output ch_tone0, ch_tone1, ch_pcm, tick
    );

    modport mix (
        input ch_tone0, ch_tone1, ch_pcm, tick
    );

endinterface

/* logic/snd_ctrl_if.sv */
// voice and gain settings, written by the command latch
interface snd_ctrl_if;

    logic [9:0] tone_period [2];  // half period, ticks
    logic [7:0] tone_vol    [2];
    logic [7:0] gain        [3];  // tone0, tone1, pcm, 4.4 format
    logic       pcm_start;        // one cycle pulse
    logic [9:0] pcm_block;        // valid with pcm_start
    logic       pcm_stop;         // one cycle pulse

    modport dec (
        output tone_period, tone_vol, gain,
        output pcm_start, pcm_block, pcm_stop
    );

    modport gen (
        input tone_period, tone_vol,
        input pcm_start, pcm_block, pcm_stop
    );

    // mixer only needs the gains
    modport mix (
        input gain
    );

endinterface

/* logic/snd_pkg.sv */
package snd_pkg;

    // command opcode, cmd_data[15:12]
    typedef enum logic [3:0] {
        OP_NOP         = 4'd0,
        OP_TONE_PERIOD = 4'd1,  // half period in ticks, 0 mutes
        OP_TONE_VOL    = 4'd2,  // volume in arg[7:0]
        OP_PCM_START   = 4'd3,  // block number in arg[9:0]
        OP_PCM_STOP    = 4'd4,
        OP_GAIN        = 4'd5   // 4.4 gain in arg[7:0]
    } snd_op_e;

    // command latch handshake
    typedef enum logic {
        IDLE  = 1'b0,  // waiting for req
        ACKED = 1'b1   // ack up, waiting for req to drop
    } snd_dec_state_e;

    // channel or mix sample
    typedef logic signed [15:0] snd_sample_t;

endpackage

/* logic/snd_macros.svh */
`ifndef SND_MACROS_SVH
`define SND_MACROS_SVH

// clocks between sample ticks
`define SND_SAMPLE_DIV 16

// bytes in one PCM block, block number scales by this
`define SND_PCM_LEN 128

// sample ROM address bits
`define SND_PCM_AW 17

// gain after reset, 1.0 in 4.4
`define SND_GAIN_RESET 8'h10

`endif
